//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_execute_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- alu.sv
`timescale 1ns/10ps

module alu (
    input  exec_pkg::alu_packet_t     alu_packet,
    output exec_pkg::cdb_reg_packet_t alu_result
);

    exec_pkg::data_t a;
    exec_pkg::data_t b;
    exec_pkg::data_t value;
    logic [4:0]      shamt;

    assign a     = alu_packet.rs1_value;
    assign b     = alu_packet.rs2_value;
    // only the low five bits count for rv32 shifts
    assign shamt = b[4:0];

    always_comb begin
        case (alu_packet.op)
            exec_pkg::alu_add: begin
                value = a + b;
            end
            exec_pkg::alu_sub: begin
                value = a - b;
            end
            exec_pkg::alu_and: begin
                value = a & b;
            end
            exec_pkg::alu_or: begin
                value = a | b;
            end
            exec_pkg::alu_xor: begin
                value = a ^ b;
            end
            exec_pkg::alu_slt: begin
                value = {31'b0, $signed(a) < $signed(b)};
            end
            exec_pkg::alu_sltu: begin
                value = {31'b0, a < b};
            end
            exec_pkg::alu_sll: begin
                value = a << shamt;
            end
            exec_pkg::alu_srl: begin
                value = a >> shamt;
            end
            exec_pkg::alu_sra: begin
                value = $signed(a) >>> shamt;
            end
            default: begin
                value = '0;
            end
        endcase
    end

    // valid and tag ride along untouched
    assign alu_result.valid          = alu_packet.valid;
    assign alu_result.completing_reg = alu_packet.dest_tag;
    assign alu_result.value          = value;

endmodule

//--- branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  exec_pkg::branch_packet_t     branch_packet,
    output exec_pkg::branch_reg_packet_t branch_reg_result,
    output exec_pkg::cdb_reg_packet_t    branch_result
);

    exec_pkg::data_t a;
    exec_pkg::data_t b;
    exec_pkg::data_t link;
    logic            cond;
    logic            taken;

    assign a    = branch_packet.rs1_value;
    assign b    = branch_packet.rs2_value;
    assign link = branch_packet.pc + 32'd4;

    always_comb begin
        case (branch_packet.op)
            exec_pkg::br_beq: begin
                cond = (a == b);
            end
            exec_pkg::br_bne: begin
                cond = (a != b);
            end
            exec_pkg::br_blt: begin
                cond = ($signed(a) < $signed(b));
            end
            exec_pkg::br_bge: begin
                cond = ($signed(a) >= $signed(b));
            end
            exec_pkg::br_bltu: begin
                cond = (a < b);
            end
            exec_pkg::br_bgeu: begin
                cond = (a >= b);
            end
            default: begin
                cond = 1'b0;
            end
        endcase
    end

    // a bubble never reports taken or mispredict
    assign taken = branch_packet.valid && cond;

    assign branch_reg_result.valid      = branch_packet.valid;
    assign branch_reg_result.taken      = taken;
    assign branch_reg_result.mispredict = branch_packet.valid &&
                                          (branch_packet.predicted_taken != cond);
    assign branch_reg_result.target     = taken ? branch_packet.pc + branch_packet.offset : link;
    assign branch_reg_result.b_mask_bit = branch_packet.b_mask_bit;

    // link value for the destination tag
    assign branch_result.valid          = branch_packet.valid;
    assign branch_result.completing_reg = branch_packet.dest_tag;
    assign branch_result.value          = link;

endmodule

//--- exec_pkg.sv
package exec_pkg;

    // datapath widths
    localparam int xlen        = 32;
    localparam int tag_bits    = 6;
    localparam int b_mask_bits = 4;

    typedef logic [xlen-1:0]        data_t;
    typedef logic [tag_bits-1:0]    tag_t;

    // one bit per unresolved branch
    typedef logic [b_mask_bits-1:0] b_mask_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // mulh is signed x signed, mulhu unsigned x unsigned
    typedef enum logic [1:0] {
        mult_mul,
        mult_mulh,
        mult_mulhu
    } mult_op_t;

    typedef enum logic [2:0] {
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } br_op_t;

    typedef struct packed {
        logic    valid;
        alu_op_t op;
        data_t   rs1_value;
        data_t   rs2_value;
        tag_t    dest_tag;
        b_mask_t b_mask;
    } alu_packet_t;

    typedef struct packed {
        logic     valid;
        mult_op_t op;
        data_t    rs1_value;
        data_t    rs2_value;
        tag_t     dest_tag;
        b_mask_t  b_mask;
    } mult_packet_t;

    typedef struct packed {
        logic    valid;
        br_op_t  op;
        data_t   rs1_value;
        data_t   rs2_value;
        data_t   pc;
        data_t   offset;
        logic    predicted_taken;
        tag_t    dest_tag;
        // the mask bit this branch owns in the branch stack
        b_mask_t b_mask_bit;
    } branch_packet_t;

    // one lane of the common data bus
    typedef struct packed {
        logic  valid;
        tag_t  completing_reg;
        data_t value;
    } cdb_reg_packet_t;

    // early tag broadcast, no value
    typedef struct packed {
        logic valid;
        tag_t completing_reg;
    } cdb_etb_packet_t;

    typedef struct packed {
        logic    valid;
        logic    taken;
        logic    mispredict;
        data_t   target;
        b_mask_t b_mask_bit;
    } branch_reg_packet_t;

    localparam alu_packet_t nop_alu_packet = '{
        valid:     1'b0,
        op:        alu_add,
        rs1_value: '0,
        rs2_value: '0,
        dest_tag:  '0,
        b_mask:    '0
    };

    localparam branch_packet_t nop_branch_packet = '{
        valid:           1'b0,
        op:              br_beq,
        rs1_value:       '0,
        rs2_value:       '0,
        pc:              '0,
        offset:          '0,
        predicted_taken: 1'b0,
        dest_tag:        '0,
        b_mask_bit:      '0
    };

endpackage

//--- execute_stage.sv
`timescale 1ns/10ps

module execute_stage #(
    parameter int n           = 2,
    parameter int num_fu_alu  = 2,
    parameter int num_fu_mult = 1,
    parameter int mult_stages = 4
) (
    input  logic                                          clock,
    input  logic                                          reset,

    // from issue
    input  exec_pkg::alu_packet_t  [num_fu_alu-1:0]       alu_packets_issuing,
    input  exec_pkg::mult_packet_t [num_fu_mult-1:0]      mult_packets_issuing,
    input  exec_pkg::branch_packet_t                      branch_packet_issuing,
    input  logic [num_fu_mult-1:0]                        mult_cdb_en,
    input  logic [n-1:0][num_fu_mult+num_fu_alu:0]        complete_grant,

    // from the branch stack
    input  exec_pkg::b_mask_t                             b_mm_resolve,
    input  logic                                          b_mm_mispred,

    output logic [num_fu_mult-1:0]                        mult_free,
    output logic [num_fu_mult-1:0]                        mult_cdb_valid,
    output exec_pkg::cdb_etb_packet_t [n-1:0]             cdb_completing,
    output exec_pkg::cdb_reg_packet_t [n-1:0]             cdb_reg,
    output exec_pkg::branch_reg_packet_t                  branch_reg
);

    // mult units, then alus, then the branch unit
    localparam int num_fu_total = num_fu_mult + num_fu_alu + 1;

    exec_pkg::alu_packet_t     [num_fu_alu-1:0]   alu_packets_q;
    exec_pkg::branch_packet_t                     branch_packet_q;

    exec_pkg::cdb_reg_packet_t [num_fu_alu-1:0]   alu_result;
    exec_pkg::cdb_reg_packet_t [num_fu_mult-1:0]  mult_result;
    exec_pkg::cdb_reg_packet_t                    branch_result;
    exec_pkg::cdb_reg_packet_t [num_fu_total-1:0] fu_result;

    exec_pkg::cdb_reg_packet_t [n-1:0]            next_cdb_reg;
    exec_pkg::branch_reg_packet_t                 next_branch_reg;

    // single-cycle units see a registered copy of issue
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_fu_alu; i++) begin
                alu_packets_q[i] <= exec_pkg::nop_alu_packet;
            end
            branch_packet_q <= exec_pkg::nop_branch_packet;
        end else begin
            alu_packets_q   <= alu_packets_issuing;
            branch_packet_q <= branch_packet_issuing;
        end
    end

    for (genvar i = 0; i < num_fu_alu; i++) begin : g_alu
        alu u_alu (
            .alu_packet (alu_packets_q[i]),
            .alu_result (alu_result[i])
        );
    end

    for (genvar i = 0; i < num_fu_mult; i++) begin : g_mult
        mult #(
            .mult_stages (mult_stages)
        ) u_mult (
            .clock          (clock),
            .reset          (reset),
            .mult_packet_in (mult_packets_issuing[i]),
            .cdb_en         (mult_cdb_en[i]),
            .b_mm_resolve   (b_mm_resolve),
            .b_mm_mispred   (b_mm_mispred),
            .fu_free        (mult_free[i]),
            .cdb_valid      (mult_cdb_valid[i]),
            .mult_result    (mult_result[i])
        );
    end

    branch_unit u_branch_unit (
        .branch_packet     (branch_packet_q),
        .branch_reg_result (next_branch_reg),
        .branch_result     (branch_result)
    );

    // index 0 is mult unit 0
    assign fu_result = {branch_result, alu_result, mult_result};

    // grant picks one unit per lane, empty lanes stay zero
    always_comb begin
        next_cdb_reg = '0;
        for (int i = 0; i < n; i++) begin
            for (int j = 0; j < num_fu_total; j++) begin
                if (complete_grant[i][j]) begin
                    next_cdb_reg[i] = fu_result[j];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < n; i++) begin
            cdb_completing[i].valid          = next_cdb_reg[i].valid;
            cdb_completing[i].completing_reg = next_cdb_reg[i].completing_reg;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_reg    <= '0;
            branch_reg <= '0;
        end else begin
            cdb_reg    <= next_cdb_reg;
            branch_reg <= next_branch_reg;
        end
    end

    // completion arbiter grants each lane to at most one unit
    for (genvar i = 0; i < n; i++) begin : g_grant_check
        a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
            $onehot0(complete_grant[i]));
    end

endmodule

//--- golden_execute.txt
# kind(0 alu, 1 alu pair with next, 2 mult, 3 branch) op rs1 rs2 pc offset pred tag mask expected flags
# mult: offset is resolve mask, flags 1 squash 2 clear; branch: expected is target, flags {taken,mispredict}
0 0 7fffffff 00000001 0 0 0 01 1 80000000 0
0 1 00000003 00000005 0 0 0 02 2 fffffffe 0
0 2 f0f01234 0ff0ffff 0 0 0 03 0 00f01234 0
0 3 f0000000 0000000f 0 0 0 04 4 f000000f 0
0 4 aaaa5555 ffff0000 0 0 0 05 8 55555555 0
0 5 ffffffff 00000001 0 0 0 06 0 00000001 0
0 6 ffffffff 00000001 0 0 0 07 0 00000000 0
0 7 00000001 00000024 0 0 0 08 0 00000010 0
0 8 80000000 0000001f 0 0 0 09 0 00000001 0
0 9 80000000 00000004 0 0 0 0a 0 f8000000 0
1 0 00001000 00000234 0 0 0 0b 0 00001234 0
0 9 7ffffff0 00000004 0 0 0 0c 0 07ffffff 0
2 0 00000007 fffffffd 0 0 0 10 1 ffffffeb 0
2 1 80000000 80000000 0 0 0 11 0 40000000 0
2 2 ffffffff ffffffff 0 0 0 12 0 fffffffe 0
2 1 ffffffff 00000002 0 0 0 13 0 ffffffff 0
2 0 00000003 00000004 0 2 0 14 2 0000000c 1
2 0 00000003 00000004 0 2 0 15 6 0000000c 2
3 0 00000005 00000005 00001000 00000040 1 20 1 00001040 2
3 0 00000005 00000006 00001100 00000040 0 21 2 00001104 0
3 1 00000005 00000006 00002000 fffffff0 0 22 4 00001ff0 3
3 1 00000007 00000007 00002010 00000100 1 23 8 00002014 1
3 2 ffffffff 00000001 00003000 00000080 1 24 1 00003080 2
3 2 00000001 ffffffff 00003100 00000080 0 25 2 00003104 0
3 3 00000001 ffffffff 00004000 00000020 0 26 4 00004020 3
3 3 80000000 00000000 00004100 00000020 1 27 8 00004104 1
3 4 00000001 ffffffff 00005000 00000010 1 28 1 00005010 2
3 4 ffffffff 00000001 00005100 00000010 0 29 2 00005104 0
3 5 ffffffff 00000001 00006000 fffff000 0 2a 4 00005000 3
3 5 00000000 00000001 00006100 00000008 1 2b 8 00006104 1

//--- mult.sv
`timescale 1ns/10ps

module mult #(
    parameter int mult_stages = 4
) (
    input  logic                      clock,
    input  logic                      reset,
    input  exec_pkg::mult_packet_t    mult_packet_in,
    input  logic                      cdb_en,
    input  exec_pkg::b_mask_t         b_mm_resolve,
    input  logic                      b_mm_mispred,
    output logic                      fu_free,
    output logic                      cdb_valid,
    output exec_pkg::cdb_reg_packet_t mult_result
);

    // multiplier bits consumed per clock
    localparam int step_bits  = 64 / mult_stages;
    localparam int count_bits = $clog2(mult_stages + 1);

    logic                   valid_q;
    exec_pkg::tag_t         tag_q;
    exec_pkg::b_mask_t      b_mask_q;
    exec_pkg::mult_op_t     op_q;
    logic [count_bits-1:0]  count;
    logic [63:0]            mcand;
    logic [63:0]            mplier;
    logic [63:0]            product;
    logic [63:0]            product_next;
    logic [63:0]            ext_a;
    logic [63:0]            ext_b;
    logic                   done;
    logic                   accept;
    logic                   squash;
    logic                   arrive_squashed;

    assign done      = (count == count_bits'(mult_stages));
    assign fu_free   = !valid_q;
    assign cdb_valid = valid_q && done;

    // packet already dead if its own mask hits a mispredict this cycle
    assign arrive_squashed = b_mm_mispred && |(mult_packet_in.b_mask & b_mm_resolve);
    assign accept          = mult_packet_in.valid && fu_free && !arrive_squashed;
    assign squash          = valid_q && b_mm_mispred && |(b_mask_q & b_mm_resolve);

    // mulhu zero extends, mul and mulh sign extend
    always_comb begin
        if (mult_packet_in.op == exec_pkg::mult_mulhu) begin
            ext_a = {32'b0, mult_packet_in.rs1_value};
            ext_b = {32'b0, mult_packet_in.rs2_value};
        end else begin
            ext_a = {{32{mult_packet_in.rs1_value[31]}}, mult_packet_in.rs1_value};
            ext_b = {{32{mult_packet_in.rs2_value[31]}}, mult_packet_in.rs2_value};
        end
    end

    // one shift-and-add slice
    always_comb begin
        product_next = product;
        for (int k = 0; k < step_bits; k++) begin
            if (mplier[k]) begin
                product_next = product_next + (mcand << k);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
            count   <= count_bits'(mult_stages);
        end else if (accept) begin
            valid_q <= 1'b1;
            count   <= '0;
        end else begin
            if (squash || (cdb_valid && cdb_en)) begin
                valid_q <= 1'b0;
            end
            if (!done) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            tag_q   <= mult_packet_in.dest_tag;
            op_q    <= mult_packet_in.op;
            mcand   <= ext_a;
            mplier  <= ext_b;
            product <= '0;
            if (b_mm_mispred) begin
                b_mask_q <= mult_packet_in.b_mask;
            end else begin
                b_mask_q <= mult_packet_in.b_mask & ~b_mm_resolve;
            end
        end else begin
            if (!done) begin
                product <= product_next;
                mcand   <= mcand << step_bits;
                mplier  <= mplier >> step_bits;
            end
            // correct resolve just retires the bit
            if (!b_mm_mispred) begin
                b_mask_q <= b_mask_q & ~b_mm_resolve;
            end
        end
    end

    assign mult_result.valid          = cdb_valid;
    assign mult_result.completing_reg = tag_q;
    assign mult_result.value          = (op_q == exec_pkg::mult_mul) ? product[31:0]
                                                                     : product[63:32];

    // issue must wait for fu_free
    a_accept_when_free: assert property (@(posedge clock) disable iff (reset)
        mult_packet_in.valid |-> fu_free);

    // a result only appears mult_stages edges after its accept
    a_valid_after_accept: assert property (@(posedge clock) disable iff (reset)
        $rose(cdb_valid) |-> $past(accept, mult_stages + 1));

endmodule

//--- sources.f
+incdir+.
exec_pkg.sv
alu.sv
mult.sv
branch_unit.sv
execute_stage.sv
tb_execute_stage.sv

//--- tb_checks.svh
`ifndef tb_checks_svh
`define tb_checks_svh

// one lane of cdb_reg
task automatic check_cdb(input string name, input exec_pkg::cdb_reg_packet_t expected,
                         input exec_pkg::cdb_reg_packet_t actual);
    if (actual !== expected) begin
        $display("error t=%0t %s expected v=%b tag=%h value=%h actual v=%b tag=%h value=%h",
                 $time, name, expected.valid, expected.completing_reg, expected.value,
                 actual.valid, actual.completing_reg, actual.value);
        stop_with_failure();
    end
endtask

// tag only, no value
task automatic check_etb(input string name, input exec_pkg::cdb_etb_packet_t expected,
                         input exec_pkg::cdb_etb_packet_t actual);
    if (actual !== expected) begin
        $display("error t=%0t %s expected v=%b tag=%h actual v=%b tag=%h",
                 $time, name, expected.valid, expected.completing_reg,
                 actual.valid, actual.completing_reg);
        stop_with_failure();
    end
endtask

task automatic check_branch(input string name, input exec_pkg::branch_reg_packet_t expected,
                            input exec_pkg::branch_reg_packet_t actual);
    if (actual !== expected) begin
        $display("error t=%0t %s expected v=%b taken=%b mis=%b target=%h bit=%h", $time, name,
                 expected.valid, expected.taken, expected.mispredict, expected.target,
                 expected.b_mask_bit);
        $display("error t=%0t %s actual v=%b taken=%b mis=%b target=%h bit=%h", $time, name,
                 actual.valid, actual.taken, actual.mispredict, actual.target,
                 actual.b_mask_bit);
        stop_with_failure();
    end
endtask

// single status bits such as mult_free
task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("error t=%0t %s expected %b actual %b", $time, name, expected, actual);
        stop_with_failure();
    end
endtask

`endif

//--- tb_execute_stage.sv
`timescale 1ns/10ps

module tb_execute_stage;

    // sizes match the DUT defaults
    localparam int n            = 2;
    localparam int num_fu_alu   = 2;
    localparam int num_fu_mult  = 1;
    localparam int mult_stages  = 4;
    localparam int branch_index = num_fu_mult + num_fu_alu;

    typedef struct packed {
        logic [3:0]        kind;
        logic [3:0]        op;
        exec_pkg::data_t   rs1;
        exec_pkg::data_t   rs2;
        exec_pkg::data_t   pc;
        exec_pkg::data_t   offset;
        logic              pred;
        exec_pkg::tag_t    tag;
        exec_pkg::b_mask_t mask;
        exec_pkg::data_t   expected;
        logic [1:0]        flags;
    } golden_rec_t;

    logic clock = 1'b0;
    logic reset;

    exec_pkg::alu_packet_t  [num_fu_alu-1:0]  alu_packets_issuing;
    exec_pkg::mult_packet_t [num_fu_mult-1:0] mult_packets_issuing;
    exec_pkg::branch_packet_t                 branch_packet_issuing;
    logic [num_fu_mult-1:0]                   mult_cdb_en;
    logic [n-1:0][num_fu_mult+num_fu_alu:0]   complete_grant;
    exec_pkg::b_mask_t                        b_mm_resolve;
    logic                                     b_mm_mispred;

    logic [num_fu_mult-1:0]                   mult_free;
    logic [num_fu_mult-1:0]                   mult_cdb_valid;
    exec_pkg::cdb_etb_packet_t [n-1:0]        cdb_completing;
    exec_pkg::cdb_reg_packet_t [n-1:0]        cdb_reg;
    exec_pkg::branch_reg_packet_t             branch_reg;

    golden_rec_t records[$];
    int          num_records = 0;

    execute_stage u_execute_stage (
        .clock                 (clock),
        .reset                 (reset),
        .alu_packets_issuing   (alu_packets_issuing),
        .mult_packets_issuing  (mult_packets_issuing),
        .branch_packet_issuing (branch_packet_issuing),
        .mult_cdb_en           (mult_cdb_en),
        .complete_grant        (complete_grant),
        .b_mm_resolve          (b_mm_resolve),
        .b_mm_mispred          (b_mm_mispred),
        .mult_free             (mult_free),
        .mult_cdb_valid        (mult_cdb_valid),
        .cdb_completing        (cdb_completing),
        .cdb_reg               (cdb_reg),
        .branch_reg            (branch_reg)
    );

    always #10 clock = ~clock;

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1, "execute stage testbench stopped");
    endtask

    `include "tb_checks.svh"

    task automatic idle_inputs();
        for (int i = 0; i < num_fu_alu; i++) begin
            alu_packets_issuing[i] = exec_pkg::nop_alu_packet;
        end
        mult_packets_issuing  = '0;
        branch_packet_issuing = exec_pkg::nop_branch_packet;
        mult_cdb_en           = '0;
        complete_grant        = '0;
        b_mm_resolve          = '0;
        b_mm_mispred          = 1'b0;
    endtask

    task automatic load_golden();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] col [11];
        golden_rec_t rec;
        fd = $fopen("golden_execute.txt", "r");
        if (fd == 0) begin
            $display("cannot open golden_execute.txt");
            stop_with_failure();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                             col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                             col[9], col[10]);
            if (fields == 11) begin
                rec.kind     = col[0][3:0];
                rec.op       = col[1][3:0];
                rec.rs1      = col[2];
                rec.rs2      = col[3];
                rec.pc       = col[4];
                rec.offset   = col[5];
                rec.pred     = col[6][0];
                rec.tag      = col[7][5:0];
                rec.mask     = col[8][3:0];
                rec.expected = col[9];
                rec.flags    = col[10][1:0];
                records.push_back(rec);
            end else if (fields > 0) begin
                $display("malformed line in golden_execute.txt: %s", line);
                stop_with_failure();
            end
        end
        $fclose(fd);
        if (records.size() == 0) begin
            $display("golden_execute.txt holds no records");
            stop_with_failure();
        end
        num_records = records.size();
    endtask

    function automatic exec_pkg::cdb_reg_packet_t lane_result(input exec_pkg::tag_t tag,
                                                              input exec_pkg::data_t value);
        exec_pkg::cdb_reg_packet_t p;
        p.valid          = 1'b1;
        p.completing_reg = tag;
        p.value          = value;
        return p;
    endfunction

    function automatic exec_pkg::alu_packet_t alu_packet_from(input golden_rec_t rec);
        exec_pkg::alu_packet_t p;
        p.valid     = 1'b1;
        p.op        = exec_pkg::alu_op_t'(rec.op);
        p.rs1_value = rec.rs1;
        p.rs2_value = rec.rs2;
        p.dest_tag  = rec.tag;
        p.b_mask    = rec.mask;
        return p;
    endfunction

    function automatic exec_pkg::mult_packet_t mult_packet_from(input golden_rec_t rec);
        exec_pkg::mult_packet_t p;
        p.valid     = 1'b1;
        p.op        = exec_pkg::mult_op_t'(rec.op[1:0]);
        p.rs1_value = rec.rs1;
        p.rs2_value = rec.rs2;
        p.dest_tag  = rec.tag;
        p.b_mask    = rec.mask;
        return p;
    endfunction

    function automatic exec_pkg::branch_packet_t branch_packet_from(input golden_rec_t rec);
        exec_pkg::branch_packet_t p;
        p.valid           = 1'b1;
        p.op              = exec_pkg::br_op_t'(rec.op[2:0]);
        p.rs1_value       = rec.rs1;
        p.rs2_value       = rec.rs2;
        p.pc              = rec.pc;
        p.offset          = rec.offset;
        p.predicted_taken = rec.pred;
        p.dest_tag        = rec.tag;
        p.b_mask_bit      = rec.mask;
        return p;
    endfunction

    // early tag view during the grant cycle
    task automatic verify_completing(input exec_pkg::cdb_reg_packet_t [n-1:0] expected);
        exec_pkg::cdb_etb_packet_t etb;
        for (int i = 0; i < n; i++) begin
            etb.valid          = expected[i].valid;
            etb.completing_reg = expected[i].completing_reg;
            check_etb($sformatf("cdb_completing[%0d]", i), etb, cdb_completing[i]);
        end
    endtask

    task automatic compare_cdb_reg_lanes(input exec_pkg::cdb_reg_packet_t [n-1:0] expected);
        for (int i = 0; i < n; i++) begin
            check_cdb($sformatf("cdb_reg[%0d]", i), expected[i], cdb_reg[i]);
        end
    endtask

    task automatic confirm_reset_state();
        exec_pkg::cdb_reg_packet_t    zero_cdb;
        exec_pkg::branch_reg_packet_t zero_branch;
        zero_cdb    = '0;
        zero_branch = '0;
        for (int i = 0; i < n; i++) begin
            check_cdb($sformatf("cdb_reg[%0d]", i), zero_cdb, cdb_reg[i]);
        end
        check_branch("branch_reg", zero_branch, branch_reg);
        check_bit("mult_cdb_valid[0]", 1'b0, mult_cdb_valid[0]);
        check_bit("mult_free[0]", 1'b1, mult_free[0]);
    endtask

    task automatic execute_alu_record(input golden_rec_t rec);
        int                                unit;
        int                                lane;
        exec_pkg::cdb_reg_packet_t [n-1:0] expected;
        unit           = $urandom_range(num_fu_alu - 1, 0);
        lane           = $urandom_range(n - 1, 0);
        expected       = '0;
        expected[lane] = lane_result(rec.tag, rec.expected);
        alu_packets_issuing[unit] = alu_packet_from(rec);
        @(negedge clock);
        alu_packets_issuing[unit] = exec_pkg::nop_alu_packet;
        complete_grant[lane][num_fu_mult + unit] = 1'b1;
        #1;
        verify_completing(expected);
        @(negedge clock);
        complete_grant = '0;
        compare_cdb_reg_lanes(expected);
    endtask

    // both alus finish together, lane order random
    task automatic complete_two_lanes(input golden_rec_t first, input golden_rec_t second);
        int                                lane_a;
        exec_pkg::cdb_reg_packet_t [n-1:0] expected;
        lane_a               = $urandom_range(n - 1, 0);
        expected[lane_a]     = lane_result(first.tag, first.expected);
        expected[1 - lane_a] = lane_result(second.tag, second.expected);
        alu_packets_issuing[0] = alu_packet_from(first);
        alu_packets_issuing[1] = alu_packet_from(second);
        @(negedge clock);
        alu_packets_issuing[0] = exec_pkg::nop_alu_packet;
        alu_packets_issuing[1] = exec_pkg::nop_alu_packet;
        complete_grant[lane_a][num_fu_mult]         = 1'b1;
        complete_grant[1 - lane_a][num_fu_mult + 1] = 1'b1;
        #1;
        verify_completing(expected);
        @(negedge clock);
        complete_grant = '0;
        compare_cdb_reg_lanes(expected);
    endtask

    task automatic multiply_and_hold(input golden_rec_t rec);
        int                                edges;
        int                                hold;
        int                                lane;
        exec_pkg::cdb_reg_packet_t [n-1:0] expected;
        check_bit("mult_free[0]", 1'b1, mult_free[0]);
        mult_packets_issuing[0] = mult_packet_from(rec);
        @(negedge clock);
        mult_packets_issuing[0] = '0;
        check_bit("mult_free[0]", 1'b0, mult_free[0]);
        edges = 0;
        // flags 1 resolves as mispredict, flags 2 as correct
        if (rec.flags != 2'd0) begin
            b_mm_resolve = rec.offset[3:0];
            b_mm_mispred = (rec.flags == 2'd1);
            @(negedge clock);
            edges        = 1;
            b_mm_resolve = '0;
            b_mm_mispred = 1'b0;
        end
        if (rec.flags == 2'd1) begin
            check_bit("mult_free[0]", 1'b1, mult_free[0]);
            repeat (mult_stages + 1) begin
                check_bit("mult_cdb_valid[0]", 1'b0, mult_cdb_valid[0]);
                @(negedge clock);
            end
        end else begin
            while (!mult_cdb_valid[0]) begin
                check_bit("mult_free[0]", 1'b0, mult_free[0]);
                @(negedge clock);
                edges++;
            end
            if (edges != mult_stages) begin
                $display("multiply result arrived %0d edges after accept, not %0d",
                         edges, mult_stages);
                stop_with_failure();
            end
            hold = $urandom_range(3, 0);
            repeat (hold) begin
                @(negedge clock);
                check_bit("mult_cdb_valid[0]", 1'b1, mult_cdb_valid[0]);
                check_bit("mult_free[0]", 1'b0, mult_free[0]);
            end
            lane           = $urandom_range(n - 1, 0);
            expected       = '0;
            expected[lane] = lane_result(rec.tag, rec.expected);
            complete_grant[lane][0] = 1'b1;
            mult_cdb_en[0]          = 1'b1;
            #1;
            verify_completing(expected);
            @(negedge clock);
            complete_grant = '0;
            mult_cdb_en    = '0;
            compare_cdb_reg_lanes(expected);
            check_bit("mult_free[0]", 1'b1, mult_free[0]);
            check_bit("mult_cdb_valid[0]", 1'b0, mult_cdb_valid[0]);
        end
    endtask

    task automatic resolve_branch_record(input golden_rec_t rec);
        int                                lane;
        exec_pkg::cdb_reg_packet_t [n-1:0] expected;
        exec_pkg::branch_reg_packet_t      expected_branch;
        lane     = $urandom_range(n - 1, 0);
        expected = '0;
        // link value for the destination tag
        expected[lane]             = lane_result(rec.tag, rec.pc + 32'd4);
        expected_branch.valid      = 1'b1;
        expected_branch.taken      = rec.flags[1];
        expected_branch.mispredict = rec.flags[0];
        expected_branch.target     = rec.expected;
        expected_branch.b_mask_bit = rec.mask;
        branch_packet_issuing = branch_packet_from(rec);
        @(negedge clock);
        branch_packet_issuing = exec_pkg::nop_branch_packet;
        complete_grant[lane][branch_index] = 1'b1;
        #1;
        verify_completing(expected);
        @(negedge clock);
        complete_grant = '0;
        compare_cdb_reg_lanes(expected);
        check_branch("branch_reg", expected_branch, branch_reg);
    endtask

    initial begin
        int idx;
        void'($urandom(32'h1346_da76));
        reset = 1'b1;
        idle_inputs();
        load_golden();
        repeat (8) @(negedge clock);
        confirm_reset_state();
        reset = 1'b0;
        idx   = 0;
        while (idx < num_records) begin
            case (records[idx].kind)
                4'd0: begin
                    execute_alu_record(records[idx]);
                    idx += 1;
                end
                4'd1: begin
                    if (idx + 1 >= num_records) begin
                        $display("two-lane record at the end of the golden file has no partner");
                        stop_with_failure();
                    end
                    complete_two_lanes(records[idx], records[idx + 1]);
                    idx += 2;
                end
                4'd2: begin
                    multiply_and_hold(records[idx]);
                    idx += 1;
                end
                4'd3: begin
                    resolve_branch_record(records[idx]);
                    idx += 1;
                end
                default: begin
                    $display("golden record %0d has unknown kind %0d", idx, records[idx].kind);
                    stop_with_failure();
                end
            endcase
        end
        @(negedge clock);
        $display("Regression passed");
        $finish;
    end

    // budget scales with the record count
    initial begin
        wait (num_records > 0);
        repeat (num_records * (mult_stages + 4) + 50) @(posedge clock);
        $display("timeout, the execute stage stopped making progress");
        stop_with_failure();
    end

endmodule
